//--- hw/stage3_fc1_pkg.sv
package stage3_fc1_pkg;

    //////////////////////////////////////////////////
    // sizes of the fc1 layer
    //////////////////////////////////////////////////

    // features per frame
    localparam int FC1_CI = 16;
    // output neurons
    localparam int FC1_CO = 3;

    // signed input feature
    localparam int IN_BW = 8;
    // signed weight
    localparam int W_BW = 8;
    // one feature x weight product
    localparam int PROD_BW = IN_BW + W_BW;
    // 16 products of 8x8 bits fit in 20 bits signed
    localparam int ACC_BW = 20;
    // signed bias from the memory file
    localparam int BIAS_BW = 16;
    // one bit over max(ACC_BW, BIAS_BW), no overflow on the add
    localparam int OUT_BW = 21;
    // feature index 0..15
    localparam int CNT_BW = 4;

    // bias values, one hex word per neuron
    localparam string BIAS_FILE = "hw/stage3_fc1_bias.mem";

    //////////////////////////////////////////////////
    // weight table, row = feature, column = neuron
    //////////////////////////////////////////////////

    localparam logic signed [W_BW-1:0] FC1_WEIGHTS [0:FC1_CI-1][0:FC1_CO-1] = '{
        '{  8'sd12,  -8'sd7,   8'sd33 },
        '{ -8'sd25,   8'sd4,   8'sd18 },
        '{  8'sd127, -8'sd3,  -8'sd40 },
        '{  8'sd9,   8'sd56,   8'sd2  },
        '{ -8'sd128, 8'sd21,  -8'sd11 },
        '{  8'sd0,  -8'sd64,   8'sd27 },
        '{  8'sd45,  8'sd13,  -8'sd8  },
        '{ -8'sd6,   8'sd90,   8'sd15 },
        '{  8'sd31, -8'sd19,  -8'sd77 },
        '{ -8'sd2,   8'sd5,    8'sd100},
        '{  8'sd17, -8'sd128,  8'sd1  },
        '{ -8'sd50,  8'sd36,  -8'sd23 },
        '{  8'sd3,   8'sd0,    8'sd127},
        '{  8'sd70, -8'sd44,   8'sd6  },
        '{ -8'sd14,  8'sd127, -8'sd90 },
        '{  8'sd22,  8'sd10,  -8'sd128}
    };

    //////////////////////////////////////////////////
    // bundled channel types
    //////////////////////////////////////////////////

    // frame sums from the accumulator
    typedef struct packed {
        logic signed [ACC_BW-1:0] ch0;
        logic signed [ACC_BW-1:0] ch1;
        logic signed [ACC_BW-1:0] ch2;
    } acc_vec_t;

    // biased results out of the core
    typedef struct packed {
        logic signed [OUT_BW-1:0] ch0;
        logic signed [OUT_BW-1:0] ch1;
        logic signed [OUT_BW-1:0] ch2;
    } result_vec_t;

endpackage

//--- hw/stage3_fc1_mac.sv
`timescale 1ns/100ps

module stage3_fc1_mac
    import stage3_fc1_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_n,

    // one feature per strobe
    input  logic                    i_in_valid,
    input  logic signed [IN_BW-1:0] i_in_feature,

    // frame sums, held after the pulse
    output logic                    o_acc_valid,
    output acc_vec_t                o_acc_sum
);

    // feature index inside the frame
    logic [CNT_BW-1:0]        r_cnt;
    // running sums of the current frame
    acc_vec_t                 r_run;

    // weight row of the current feature
    logic signed [W_BW-1:0]    w_wt0;
    logic signed [W_BW-1:0]    w_wt1;
    logic signed [W_BW-1:0]    w_wt2;

    // products
    logic signed [PROD_BW-1:0] w_prod0;
    logic signed [PROD_BW-1:0] w_prod1;
    logic signed [PROD_BW-1:0] w_prod2;

    // running sums including this feature
    acc_vec_t                 w_next;

    // last feature of the frame
    logic                     w_last;

    //////////////////////////////////////////////////
    // multiply stage
    //////////////////////////////////////////////////

    // row select by feature index
    assign w_wt0 = FC1_WEIGHTS[r_cnt][0];
    assign w_wt1 = FC1_WEIGHTS[r_cnt][1];
    assign w_wt2 = FC1_WEIGHTS[r_cnt][2];

    // signed x signed, full width
    assign w_prod0 = i_in_feature * w_wt0;
    assign w_prod1 = i_in_feature * w_wt1;
    assign w_prod2 = i_in_feature * w_wt2;

    // products sign extended to the sum width
    always_comb begin
        w_next.ch0 = r_run.ch0 + ACC_BW'(w_prod0);
        w_next.ch1 = r_run.ch1 + ACC_BW'(w_prod1);
        w_next.ch2 = r_run.ch2 + ACC_BW'(w_prod2);
    end

    assign w_last = (r_cnt == CNT_BW'(FC1_CI - 1));

    //////////////////////////////////////////////////
    // index and running sums
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_cnt <= '0;
            r_run <= '0;
        end else if (i_in_valid) begin
            if (w_last) begin
                // frame done, restart from zero
                r_cnt <= '0;
                r_run <= '0;
            end else begin
                r_cnt <= r_cnt + 1'b1;
                r_run <= w_next;
            end
        end
    end

    //////////////////////////////////////////////////
    // output register and pulse
    //////////////////////////////////////////////////

    // held output lets the next frame start right away
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_acc_sum <= '0;
        end else if (i_in_valid && w_last) begin
            o_acc_sum <= w_next;
        end
    end

    // one cycle after the 16th strobe
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_acc_valid <= 1'b0;
        end else begin
            o_acc_valid <= i_in_valid && w_last;
        end
    end

endmodule

//--- hw/stage3_cnn_core.sv
`timescale 1ns/100ps

module stage3_cnn_core
    import stage3_fc1_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,

    // sum pulse from the accumulator
    input  logic        i_in_valid,
    input  acc_vec_t    i_acc_sum,

    // biased results
    output logic        o_ot_valid,
    output result_vec_t o_ot_result
);

    // per-neuron bias
    logic signed [BIAS_BW-1:0] bias_mem [0:FC1_CO-1];

    // sum plus bias, before the register
    result_vec_t w_result;

    // valid delay, one stage
    logic        r_valid;

    // bias loaded once
    initial begin
        $readmemh(BIAS_FILE, bias_mem);
    end

    //////////////////////////////////////////////////
    // bias add
    //////////////////////////////////////////////////

    // both sides sign extended to OUT_BW
    always_comb begin
        w_result.ch0 = OUT_BW'(i_acc_sum.ch0) + OUT_BW'(bias_mem[0]);
        w_result.ch1 = OUT_BW'(i_acc_sum.ch1) + OUT_BW'(bias_mem[1]);
        w_result.ch2 = OUT_BW'(i_acc_sum.ch2) + OUT_BW'(bias_mem[2]);
    end

    //////////////////////////////////////////////////
    // result register
    //////////////////////////////////////////////////

    // captured on the sum pulse, held until the next
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_ot_result <= '0;
        end else if (i_in_valid) begin
            o_ot_result <= w_result;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_valid <= 1'b0;
        end else begin
            r_valid <= i_in_valid;
        end
    end

    assign o_ot_valid = r_valid;

endmodule

//--- hw/stage3_fc1_top.sv
`timescale 1ns/100ps

module stage3_fc1_top
    import stage3_fc1_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_n,

    // pooled feature stream
    input  logic                    i_in_valid,
    input  logic signed [IN_BW-1:0] i_in_feature,

    // one result pulse per frame
    output logic                    o_ot_valid,
    output result_vec_t             o_ot_result
);

    // accumulator to core
    logic     w_acc_valid;
    acc_vec_t w_acc_sum;

    //////////////////////////////////////////////////
    // multiply-accumulate over 16 features
    //////////////////////////////////////////////////

    stage3_fc1_mac stage3_fc1_mac_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_in_valid   (i_in_valid),
        .i_in_feature (i_in_feature),
        .o_acc_valid  (w_acc_valid),
        .o_acc_sum    (w_acc_sum)
    );

    //////////////////////////////////////////////////
    // bias add and output register
    //////////////////////////////////////////////////

    stage3_cnn_core stage3_cnn_core_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_in_valid  (w_acc_valid),
        .i_acc_sum   (w_acc_sum),
        .o_ot_valid  (o_ot_valid),
        .o_ot_result (o_ot_result)
    );

endmodule

//--- sim/tb_stage3_fc1.sv
`timescale 1ns/100ps

module tb_stage3_fc1
    import stage3_fc1_pkg::*;
();

    // frames in the stimulus table
    localparam int NUM_FRAMES = 6;
    // worst case 3 idle cycles per strobe plus pipeline and reset slack
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * (FC1_CI * 4 + 4) + 50;

    logic                    clk = 1'b0;
    logic                    reset_n;
    logic                    in_valid;
    logic signed [IN_BW-1:0] in_feature;
    logic                    ot_valid;
    result_vec_t             ot_result;

    // bias values for the reference model
    logic signed [BIAS_BW-1:0] bias_ref [0:FC1_CO-1];

    // expected results and the cycle of each pulse
    result_vec_t res_q [$];
    int          cyc_q [$];

    // last result seen by the hold check
    result_vec_t last_result = '0;
    logic        have_result = 1'b0;
    int          cycle_cnt = 0;

    //////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////

    // frame 2 repeats frame 0 with gaps
    // frames 4 and 5 sit at the extremes
    logic signed [IN_BW-1:0] stim_feat [0:NUM_FRAMES-1][0:FC1_CI-1] = '{
        '{ 8'sd5,   -8'sd3,   8'sd17,  -8'sd22,  8'sd9,   8'sd0,   8'sd31,  -8'sd8,
           8'sd14,  -8'sd1,   8'sd6,   -8'sd19,  8'sd27,  8'sd3,  -8'sd12,   8'sd10 },
        '{-8'sd40,   8'sd25, -8'sd7,    8'sd63, -8'sd100, 8'sd12,  8'sd8,   -8'sd55,
           8'sd90,  -8'sd18,  8'sd44,  -8'sd2,   8'sd71, -8'sd33,  8'sd15,  -8'sd64 },
        '{ 8'sd5,   -8'sd3,   8'sd17,  -8'sd22,  8'sd9,   8'sd0,   8'sd31,  -8'sd8,
           8'sd14,  -8'sd1,   8'sd6,   -8'sd19,  8'sd27,  8'sd3,  -8'sd12,   8'sd10 },
        '{ 8'sd127, -8'sd128, 8'sd64,  -8'sd64,  8'sd1,  -8'sd1,   8'sd100, -8'sd100,
           8'sd50,  -8'sd50,  8'sd23,  -8'sd23,  8'sd7,  -8'sd7,   8'sd88,  -8'sd88 },
        '{default: -8'sd128},
        '{default: 8'sd127}
    };

    // 1 = random idle gaps of 0 to 3 cycles before each strobe
    logic stim_gaps [0:NUM_FRAMES-1] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1};

    stage3_fc1_top stage3_fc1_top_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_in_valid   (in_valid),
        .i_in_feature (in_feature),
        .o_ot_valid   (ot_valid),
        .o_ot_result  (ot_result)
    );

    always #5 clk = ~clk;

    // cycle count and run limit
    always @(posedge clk) begin
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run("run timed out before all frames came out of the DUT");
        end else begin
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    //////////////////////////////////////////////////
    // reference model and checks
    //////////////////////////////////////////////////

    // dot product of one table frame plus bias
    function automatic result_vec_t expected_result(input int f);
        int          sums [0:FC1_CO-1];
        result_vec_t r;
        for (int n = 0; n < FC1_CO; n++) begin
            sums[n] = int'(bias_ref[n]);
            for (int k = 0; k < FC1_CI; k++) begin
                sums[n] += int'(stim_feat[f][k]) * int'(FC1_WEIGHTS[k][n]);
            end
        end
        r.ch0 = OUT_BW'(sums[0]);
        r.ch1 = OUT_BW'(sums[1]);
        r.ch2 = OUT_BW'(sums[2]);
        return r;
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_result(input result_vec_t got, input result_vec_t exp,
                                input string what);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t: %s, got %0d/%0d/%0d expected %0d/%0d/%0d",
                $time, what, got.ch0, got.ch1, got.ch2, exp.ch0, exp.ch1, exp.ch2));
        end
    endtask

    task automatic check_valid(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t: o_ot_valid %s, got %b expected %b",
                $time, what, got, exp));
        end
    endtask

    // outputs sampled on the falling edge
    always @(negedge clk) begin
        logic exp_v;
        exp_v = 1'b0;
        if (!reset_n) begin
            last_result = '0;
            check_valid(ot_valid, 1'b0, "during reset");
            check_result(ot_result, '0, "result during reset");
        end else begin
            if (cyc_q.size() != 0) begin
                exp_v = (cyc_q[0] == cycle_cnt);
            end
            check_valid(ot_valid, exp_v, "pulse timing");
            if (ot_valid) begin
                check_result(ot_result, res_q.pop_front(), "frame result");
                void'(cyc_q.pop_front());
                last_result = ot_result;
                have_result = 1'b1;
            end else if (have_result) begin
                // held between pulses
                check_result(ot_result, last_result, "held result");
            end
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    // entered and left 1 ns after a rising edge
    task automatic drive_frame(input int f, input int n_feat);
        int gap;
        for (int k = 0; k < n_feat; k++) begin
            gap = stim_gaps[f] ? int'($urandom_range(3, 0)) : 0;
            repeat (gap) begin
                in_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            in_valid   = 1'b1;
            in_feature = stim_feat[f][k];
            if (k == FC1_CI - 1) begin
                // sampled on the next edge
                // pulse two cycles after that edge
                res_q.push_back(expected_result(f));
                cyc_q.push_back(cycle_cnt + 2);
            end
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    // last strobe already sampled
    // pulse comes in the second cycle after that edge
    task automatic wait_result_latency();
        repeat (2) @(posedge clk);
        #1;
    endtask

    initial begin
        void'($urandom(35));
        in_valid   = 1'b0;
        in_feature = '0;
        reset_n    = 1'b0;
        $readmemh(BIAS_FILE, bias_ref);
        repeat (2) @(posedge clk);
        #1;
        reset_n = 1'b1;

        // table frames back to back unless gaps are on
        for (int f = 0; f < NUM_FRAMES; f++) begin
            drive_frame(f, FC1_CI);
        end
        wait_result_latency();

        // partial frame cut by reset
        drive_frame(3, FC1_CI / 2);
        reset_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset_n = 1'b1;
        drive_frame(1, FC1_CI);
        wait_result_latency();
        repeat (4) @(posedge clk);

        if (res_q.size() != 0) begin
            abort_run("frames still pending at the end of the run");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

//--- hw/stage3_fc1_bias.mem
// bias per neuron, 16-bit signed hex, neuron 0 to 2
0064
FF38
01F4

//--- project.f
hw/stage3_fc1_pkg.sv
hw/stage3_fc1_mac.sv
hw/stage3_cnn_core.sv
hw/stage3_fc1_top.sv
sim/tb_stage3_fc1.sv

//--- Bender.yml
package:
  name: stage3_fc1

sources:
  - files:
      - hw/stage3_fc1_pkg.sv
  - files:
      - hw/stage3_fc1_mac.sv
      - hw/stage3_cnn_core.sv
      - hw/stage3_fc1_top.sv
  - target: simulation
    files:
      - sim/tb_stage3_fc1.sv
